// File: hw/snd_defs.svh
// Width macros for the sound board
// Work RAM, program ROM and timer sizes
`ifndef SND_DEFS_SVH
`define SND_DEFS_SVH

// Work RAM address width
// Board jumper on A10 selects 1kB or 2kB, 10 is the common fit
`define SND_RAM_AW 10

// Program ROM address width, 16kB over regions 0 and 1
`define SND_ROM_AW 14

// Free-running timer width
// Top two bits are what the CPU polls
`define SND_CNT_W 11

`endif

// File: hw/snd_pkg.sv
// Shared types for the sound board
// Bus, sample and level typedefs, bus region enum
package snd_pkg;

    typedef logic [15:0]        addr_t;     // Sound CPU address
    typedef logic [7:0]         byte_t;     // CPU data, latch, DAC level
    typedef logic signed [15:0] sample_t;   // Signed audio out
    typedef logic [2:0]         cap_t;      // Filter strength

    // Decoded region of the current bus cycle
    typedef enum logic [2:0] {
        REG_ROM,    // 0000-3FFF
        REG_RAM,    // 4000-5FFF
        REG_LATCH,  // 6000-7FFF, read only
        REG_TIMER,  // 8000-9FFF, read only
        REG_NONE,   // A000 and holes in E000
        REG_CTRL,   // C000-DFFF, address carries the data
        REG_DAC     // E000, write only
    } region_e;

endpackage

// File: hw/snd_cmd_latch.sv
// Main to sound CPU command latch
// Holds the command byte and the pending sound interrupt
`timescale 1ns/1ps

module snd_cmd_latch (
    input  logic           clk,
    input  logic           rst,
    input  snd_pkg::byte_t main_dout,
    input  logic           m2s_data,   // Main CPU writes the latch
    input  logic           m2s_irq,    // Main CPU kicks the sound CPU
    input  logic           latch_rd,   // Sound CPU reads the latch
    output snd_pkg::byte_t latch,
    output logic           snd_irq
);

    // Command byte
    always_ff @(posedge clk) begin
        if (m2s_data) latch <= main_dout;
    end

    // Interrupt stays up until the command is picked up
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd_irq <= 1'b0;
        end else begin
            if (m2s_irq)
                snd_irq <= 1'b1;    // New request wins over a read
            else if (latch_rd)
                snd_irq <= 1'b0;
        end
    end

    // IRQ only rises after a request from the main side
    a_irq_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(snd_irq) |-> $past(m2s_irq));

endmodule

// File: hw/snd_ram.sv
// Sound CPU work RAM
// Synchronous write, asynchronous read
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_ram (
    input  logic                   clk,
    input  logic                   ram_cs,
    input  logic                   ram_we,
    input  logic [`SND_RAM_AW-1:0] addr,
    input  snd_pkg::byte_t         din,
    output snd_pkg::byte_t         dout
);

    snd_pkg::byte_t mem [2**`SND_RAM_AW];

    always_ff @(posedge clk) begin
        if (ram_cs && ram_we) mem[addr] <= din;
    end

    // Read is registered by the decoder
    assign dout = mem[addr];

endmodule

// File: hw/snd_timer.sv
// Free-running timer for music pacing
// Counts CPU clock enables, top bits read back by the CPU
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_timer (
    input  logic       clk,
    input  logic       rst,
    input  logic       snd_cen,
    output logic [1:0] cnt_top
);

    logic [`SND_CNT_W-1:0] cnt;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (snd_cen) begin
            cnt <= cnt + 1'b1;  // Wraps
        end
    end

    // Two MSBs give a slow square wave
    assign cnt_top = cnt[`SND_CNT_W-1:`SND_CNT_W-2];

endmodule

// File: hw/snd_mixer.sv
// DAC level register and one-pole low-pass filter
// Mute, sample strobe and peak flag
`timescale 1ns/1ps

module snd_mixer (
    input  logic             clk,
    input  logic             rst,
    input  logic             smp_cen,
    input  logic             dac_we,
    input  snd_pkg::byte_t   dac_din,
    input  snd_pkg::cap_t    cap_en,
    input  logic             mute,
    output snd_pkg::sample_t snd,
    output logic             sample,
    output logic             peak
);

    snd_pkg::byte_t     level;
    snd_pkg::sample_t   target;
    logic signed [16:0] diff;      // Full range of target minus acc
    logic signed [16:0] step;
    logic signed [16:0] acc_nxt;

    // DAC level, midscale is silence
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            level <= 8'h80;
        end else if (dac_we) begin
            level <= dac_din;
        end
    end

    always_comb begin
        // Offset binary to two's complement, scaled to 16 bits
        target  = mute ? '0 : {~level[7], level[6:0], 8'h00};
        diff    = {target[15], target} - {snd[15], snd};
        // Larger cap_en means a bigger capacitor
        step    = diff >>> cap_en;
        acc_nxt = {snd[15], snd} + step;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd    <= '0;
            sample <= 1'b0;
            peak   <= 1'b0;
        end else begin
            sample <= smp_cen;
            if (smp_cen) begin
                snd  <= acc_nxt[15:0];  // Always between acc and target
                peak <= level == 8'h00 || level == 8'hff;
            end else begin
                peak <= 1'b0;
            end
        end
    end

    // Sample strobe follows the rate enable by one clock
    a_sample_cen: assert property (@(posedge clk) disable iff (rst)
        sample |-> $past(smp_cen));

endmodule

// File: hw/snd_map.sv
// Sound CPU address decoder
// Chip selects, control register and registered read mux
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_map (
    input  logic                   clk,
    input  logic                   rst,
    input  snd_pkg::addr_t         cpu_addr,
    input  logic                   cpu_mreq_n,
    input  logic                   cpu_wr_n,
    input  snd_pkg::byte_t         rom_data,
    input  logic                   rom_ok,
    input  snd_pkg::byte_t         ram_dout,
    input  snd_pkg::byte_t         latch,
    input  logic [1:0]             cnt_top,
    output snd_pkg::byte_t         cpu_din,
    output logic                   cpu_wait,
    output logic                   rom_cs,
    output logic [`SND_ROM_AW-1:0] rom_addr,
    output logic                   ram_cs,
    output logic                   ram_we,
    output logic                   latch_rd,
    output logic                   dac_we,
    output snd_pkg::cap_t          cap_en,
    output logic                   mute
);

    snd_pkg::region_e region;
    logic             active;
    logic             ctrl_we;

    // Region from the top three address bits
    always_comb begin
        case (cpu_addr[15:13])
            3'd0, 3'd1: region = snd_pkg::REG_ROM;
            3'd2:       region = snd_pkg::REG_RAM;
            3'd3:       region = snd_pkg::REG_LATCH;
            3'd4:       region = snd_pkg::REG_TIMER;
            3'd6:       region = snd_pkg::REG_CTRL;
            3'd7: begin
                // Only E000 itself, E001 and up belong to the PSG
                if (cpu_addr[2:0] == 3'd0) region = snd_pkg::REG_DAC;
                else                       region = snd_pkg::REG_NONE;
            end
            default:    region = snd_pkg::REG_NONE;  // A000 speech area
        endcase
    end

    assign active   = !cpu_mreq_n;

    assign rom_cs   = active && region == snd_pkg::REG_ROM;
    assign ram_cs   = active && region == snd_pkg::REG_RAM;
    assign ram_we   = ram_cs && !cpu_wr_n;
    assign latch_rd = active && region == snd_pkg::REG_LATCH && cpu_wr_n;
    assign ctrl_we  = active && region == snd_pkg::REG_CTRL && !cpu_wr_n;
    assign dac_we   = active && region == snd_pkg::REG_DAC && !cpu_wr_n;

    assign rom_addr = cpu_addr[`SND_ROM_AW-1:0];
    assign cpu_wait = rom_cs && !rom_ok;    // Hold the CPU until SDRAM delivers

    // Control register, data is taken from the address lines
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cap_en <= '0;
            mute   <= 1'b1;     // Silent until the CPU sets it up
        end else if (ctrl_we) begin
            cap_en <= cpu_addr[5:3];
            mute   <= cpu_addr[6];
        end
    end

    // Read data, valid the cycle after the bus edge
    always_ff @(posedge clk) begin
        if (active && !cpu_wait) begin
            case (region)
                snd_pkg::REG_ROM:   cpu_din <= rom_data;
                snd_pkg::REG_RAM:   cpu_din <= ram_dout;
                snd_pkg::REG_LATCH: cpu_din <= latch;
                snd_pkg::REG_TIMER: cpu_din <= {6'h3f, cnt_top};  // Busy bits float high
                default:            cpu_din <= 8'hff;
            endcase
        end
    end

    // Selects never overlap
    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, latch_rd, ctrl_we, dac_we}));

    // Nothing selected outside a bus cycle
    a_sel_idle: assert property (@(posedge clk) disable iff (rst)
        cpu_mreq_n |-> !(rom_cs || ram_cs || ram_we || latch_rd || ctrl_we || dac_we));

endmodule

// File: hw/snd_board.sv
// Sound board top level
// Bus decode, command latch, work RAM, timer and DAC mixer
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_board (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   snd_cen,    // CPU clock enable
    input  logic                   smp_cen,    // Audio sample rate enable
    // Sound CPU bus
    input  snd_pkg::addr_t         cpu_addr,
    input  snd_pkg::byte_t         cpu_dout,
    input  logic                   cpu_mreq_n,
    input  logic                   cpu_wr_n,
    output snd_pkg::byte_t         cpu_din,
    output logic                   cpu_wait,
    output logic                   snd_irq,
    // Program ROM
    output logic [`SND_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    input  snd_pkg::byte_t         rom_data,
    input  logic                   rom_ok,
    // From main CPU
    input  snd_pkg::byte_t         main_dout,
    input  logic                   m2s_data,
    input  logic                   m2s_irq,
    // Audio
    output snd_pkg::sample_t       snd,
    output logic                   sample,
    output logic                   peak
);

    snd_pkg::byte_t ram_dout;
    snd_pkg::byte_t latch;
    snd_pkg::cap_t  cap_en;
    logic [1:0]     cnt_top;
    logic           ram_cs, ram_we;
    logic           latch_rd;
    logic           dac_we;
    logic           mute;

    snd_map u_map (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_mreq_n ( cpu_mreq_n ),
        .cpu_wr_n   ( cpu_wr_n   ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .ram_dout   ( ram_dout   ),
        .latch      ( latch      ),
        .cnt_top    ( cnt_top    ),
        .cpu_din    ( cpu_din    ),
        .cpu_wait   ( cpu_wait   ),
        .rom_cs     ( rom_cs     ),
        .rom_addr   ( rom_addr   ),
        .ram_cs     ( ram_cs     ),
        .ram_we     ( ram_we     ),
        .latch_rd   ( latch_rd   ),
        .dac_we     ( dac_we     ),
        .cap_en     ( cap_en     ),
        .mute       ( mute       )
    );

    snd_cmd_latch u_latch (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .main_dout  ( main_dout  ),
        .m2s_data   ( m2s_data   ),
        .m2s_irq    ( m2s_irq    ),
        .latch_rd   ( latch_rd   ),
        .latch      ( latch      ),
        .snd_irq    ( snd_irq    )
    );

    // Low address bits only, RAM is mirrored inside its region
    snd_ram u_ram (
        .clk        ( clk                          ),
        .ram_cs     ( ram_cs                       ),
        .ram_we     ( ram_we                       ),
        .addr       ( cpu_addr[`SND_RAM_AW-1:0]    ),
        .din        ( cpu_dout                     ),
        .dout       ( ram_dout                     )
    );

    snd_timer u_timer (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .snd_cen    ( snd_cen    ),
        .cnt_top    ( cnt_top    )
    );

    snd_mixer u_mixer (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .smp_cen    ( smp_cen    ),
        .dac_we     ( dac_we     ),
        .dac_din    ( cpu_dout   ),  // DAC level comes on the data bus
        .cap_en     ( cap_en     ),
        .mute       ( mute       ),
        .snd        ( snd        ),
        .sample     ( sample     ),
        .peak       ( peak       )
    );

endmodule

// File: bench/snd_board_tb.sv
// Sound board testbench
// Clock, reset, ROM model, CPU bus tasks, reference models and checks
`timescale 1ns/1ps
`include "snd_defs.svh"

module snd_board_tb;

    logic                   clk, rst, snd_cen, smp_cen;
    snd_pkg::addr_t         cpu_addr;
    snd_pkg::byte_t         cpu_dout, cpu_din, rom_data, main_dout;
    logic                   cpu_mreq_n, cpu_wr_n, cpu_wait, snd_irq;
    logic [`SND_ROM_AW-1:0] rom_addr;
    logic                   rom_cs, rom_ok, m2s_data, m2s_irq;
    snd_pkg::sample_t       snd;
    logic                   sample, peak;

    int unsigned      seed;
    int               n_checks, n_value_err, n_timeouts;
    int               cen_count, cnt_snap, n_samples;
    snd_pkg::byte_t   ref_level;            // Shadow of the DAC level
    snd_pkg::cap_t    ref_cap;
    logic             ref_mute;
    snd_pkg::sample_t ref_acc;              // Filter state after the last sample
    snd_pkg::byte_t   ram_model [2**`SND_RAM_AW];

    snd_board DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ROM contents mix every address bit
    function automatic snd_pkg::byte_t rom_byte(input logic [`SND_ROM_AW-1:0] a);
        return (a[7:0] ^ {a[5:0], a[13:12]}) + a[13:6] + 8'h3c;
    endfunction

    // Timer read value is six ones over the two MSBs
    function automatic snd_pkg::byte_t timer_status(input int count);
        logic [`SND_CNT_W-1:0] c;
        c = count;                          // Wraps like the hardware
        return {6'h3f, c[`SND_CNT_W-1 -: 2]};
    endfunction

    // One filter step toward the DAC target
    function automatic snd_pkg::sample_t filter_next(input snd_pkg::sample_t acc,
            input snd_pkg::byte_t level, input snd_pkg::cap_t cap, input logic mute);
        int target;
        int diff;
        target = mute ? 0 : (int'(level) - 128) * 256;
        diff   = target - int'(acc);
        return snd_pkg::sample_t'(int'(acc) + (diff >>> cap));
    endfunction

    task automatic check_byte(input string name, input snd_pkg::byte_t got,
            input snd_pkg::byte_t exp);
        n_checks++;
        if (got !== exp) begin
            n_value_err++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_sample(input string name, input snd_pkg::sample_t got,
            input snd_pkg::sample_t exp);
        n_checks++;
        if (got !== exp) begin
            n_value_err++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_value_err++;
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string msg);
        n_timeouts++;
        $display("ERROR at %0t: timed out, %s", $time, msg);
    endtask

    // Read cycle held while the board asserts wait
    task automatic bus_read(input snd_pkg::addr_t a, output snd_pkg::byte_t d);
        int n;
        @(posedge clk);
        #2;
        cpu_addr   = a;
        cpu_mreq_n = 1'b0;
        cpu_wr_n   = 1'b1;
        n = 0;
        @(negedge clk);
        while (cpu_wait && n < 20) begin
            n++;
            @(negedge clk);
        end
        if (cpu_wait) report_timeout($sformatf("read at %h stuck in wait", a));
        cnt_snap = cen_count;               // Timer value seen by the capture edge
        @(posedge clk);
        #2;
        d          = cpu_din;
        cpu_mreq_n = 1'b1;
    endtask

    task automatic bus_write(input snd_pkg::addr_t a, input snd_pkg::byte_t d);
        @(posedge clk);
        #2;
        cpu_addr   = a;
        cpu_dout   = d;
        cpu_mreq_n = 1'b0;
        cpu_wr_n   = 1'b0;
        @(posedge clk);                     // Write lands here
        #2;
        cpu_mreq_n = 1'b1;
        cpu_wr_n   = 1'b1;
    endtask

    // Control register value rides on the address
    task automatic write_ctrl(input snd_pkg::cap_t cap, input logic mute);
        bus_write(16'hc000 | {mute, cap, 3'b000}, $urandom);
        ref_cap  = cap;
        ref_mute = mute;
    endtask

    task automatic write_dac(input snd_pkg::byte_t level);
        bus_write(16'he000, level);
        ref_level = level;
    endtask

    task automatic send_command(input snd_pkg::byte_t c, input logic irq);
        @(posedge clk);
        #2;
        main_dout = c;
        m2s_data  = 1'b1;
        m2s_irq   = irq;
        @(posedge clk);
        #2;
        m2s_data  = 1'b0;
        m2s_irq   = 1'b0;
    endtask

    task automatic wait_samples(input int k);
        int start;
        int n;
        start = n_samples;
        n = 0;
        while (n_samples < start + k && n < 400) begin
            n++;
            @(negedge clk);
        end
        if (n_samples < start + k) report_timeout("sample pulses stopped");
    endtask

    // New clock enable draw every cycle
    initial begin
        forever begin
            @(posedge clk);
            #2;
            snd_cen = $urandom_range(0, 1);
            smp_cen = ($urandom_range(0, 3) == 0);
        end
    end

    // Pulses the timer has seen
    initial begin
        cen_count = 0;
        forever begin
            @(posedge clk);
            if (!rst && snd_cen) cen_count++;
        end
    end

    // ROM model with random latency and junk data until ok
    initial begin : rom_model
        logic                   cs_seen;
        logic                   pend;
        logic [`SND_ROM_AW-1:0] a_seen;
        int                     delay;
        pend  = 1'b0;
        delay = 0;
        forever begin
            @(posedge clk);
            cs_seen = rom_cs;
            a_seen  = rom_addr;
            #2;
            if (!cs_seen) begin
                pend   = 1'b0;
                rom_ok = 1'b0;
            end else if (!pend) begin
                pend     = 1'b1;
                delay    = $urandom_range(0, 3);
                rom_data = ~rom_byte(a_seen);
            end
            if (pend && !rom_ok) begin
                if (delay == 0) begin
                    rom_ok   = 1'b1;
                    rom_data = rom_byte(a_seen);
                end else begin
                    delay--;
                end
            end
        end
    end

    // Mixer compare predicts each sample from the shadow state
    initial begin : sample_compare
        snd_pkg::sample_t exp_snd;
        logic             exp_peak;
        logic             pend;
        pend      = 1'b0;
        exp_snd   = '0;
        exp_peak  = 1'b0;
        n_samples = 0;
        ref_acc   = '0;
        forever begin
            @(negedge clk);
            if (rst) begin
                pend    = 1'b0;
                ref_acc = '0;
            end else begin
                if (pend) begin
                    check_bit("sample", sample, 1'b1);
                    check_sample("snd", snd, exp_snd);
                    check_bit("peak", peak, exp_peak);
                    ref_acc = exp_snd;
                    n_samples++;
                end else begin
                    check_bit("sample", sample, 1'b0);
                    check_bit("peak", peak, 1'b0);
                    check_sample("snd", snd, ref_acc);  // Holds between samples
                end
                pend = smp_cen;
                if (smp_cen) begin
                    exp_snd  = filter_next(ref_acc, ref_level, ref_cap, ref_mute);
                    exp_peak = ref_level == 8'h00 || ref_level == 8'hff;
                end
            end
        end
    end

    initial begin : main_seq
        snd_pkg::addr_t a;
        snd_pkg::addr_t wr_q [$];
        snd_pkg::byte_t d;
        snd_pkg::byte_t cmd;
        snd_pkg::cap_t  cap;
        int             n;
        seed = $urandom(71983);
        n_checks    = 0;
        n_value_err = 0;
        n_timeouts  = 0;
        rst = 1'b1;
        snd_cen = 1'b0;
        smp_cen = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        cpu_mreq_n = 1'b1;
        cpu_wr_n = 1'b1;
        rom_data = '0;
        rom_ok = 1'b0;
        main_dout = '0;
        m2s_data = 1'b0;
        m2s_irq = 1'b0;
        ref_level = 8'h80;
        ref_cap = '0;
        ref_mute = 1'b1;
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;

        // Reset state before anything is clocked
        @(negedge clk);
        check_bit("snd_irq", snd_irq, 1'b0);
        check_bit("sample", sample, 1'b0);
        check_bit("peak", peak, 1'b0);
        check_bit("cpu_wait", cpu_wait, 1'b0);
        check_bit("rom_cs", rom_cs, 1'b0);
        check_sample("snd", snd, '0);
        wait_samples(4);
        check_sample("snd", snd, '0);       // Muted by default

        // ROM reads through wait states
        repeat (12) begin
            a = {2'b00, 14'($urandom)};
            bus_read(a, d);
            check_byte("cpu_din", d, rom_byte(a[13:0]));
        end

        // RAM write then read back
        repeat (16) begin
            a = {3'b010, 13'($urandom)};
            d = $urandom;
            bus_write(a, d);
            ram_model[a[`SND_RAM_AW-1:0]] = d;
            wr_q.push_back(a);
        end
        foreach (wr_q[i]) begin
            bus_read(wr_q[i], d);
            check_byte("cpu_din", d, ram_model[wr_q[i][`SND_RAM_AW-1:0]]);
        end
        repeat (4) begin
            bus_read({3'b101, 13'($urandom)}, d);
            check_byte("cpu_din", d, 8'hff);    // Unmapped
        end

        // Command latch with interrupt
        repeat (3) begin
            cmd = $urandom;
            send_command(cmd, 1'b1);
            n = 0;
            @(negedge clk);
            while (!snd_irq && n < 20) begin
                n++;
                @(negedge clk);
            end
            if (!snd_irq) report_timeout("snd_irq did not rise after a command");
            bus_read({3'b011, 13'($urandom)}, d);
            check_byte("cpu_din", d, cmd);
            check_bit("snd_irq", snd_irq, 1'b0);
        end
        cmd = $urandom;
        send_command(cmd, 1'b0);            // Data only without interrupt
        @(negedge clk);
        check_bit("snd_irq", snd_irq, 1'b0);
        bus_read(16'h6000, d);
        check_byte("cpu_din", d, cmd);

        // Timer polling
        repeat (5) begin
            repeat (300 + $urandom_range(0, 200)) @(posedge clk);
            bus_read({3'b100, 13'($urandom)}, d);
            check_byte("cpu_din", d, timer_status(cnt_snap));
        end

        // Filter runs with peaks at both rails
        for (int k = 0; k < 6; k++) begin
            cap = (k == 0) ? 3'd0 : 3'($urandom_range(1, 7));
            write_ctrl(cap, 1'b0);
            write_dac(8'h00);
            wait_samples(5);
            write_dac(8'hff);
            wait_samples(5);
            repeat (2) begin
                write_dac($urandom);
                wait_samples(5);
            end
        end
        write_ctrl(3'd3, 1'b1);
        wait_samples(8);
        write_ctrl(3'd0, 1'b1);             // Straight copy of a zero target
        wait_samples(3);
        check_sample("snd", snd, '0);

        repeat (4) @(negedge clk);
        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 n_checks, n_value_err, n_timeouts);
        if (n_value_err == 0 && n_timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: snd_board.f
+incdir+hw
hw/snd_pkg.sv
hw/snd_cmd_latch.sv
hw/snd_ram.sv
hw/snd_timer.sv
hw/snd_mixer.sv
hw/snd_map.sv
hw/snd_board.sv
bench/snd_board_tb.sv

// File: Bender.yml
package:
  name: snd_board

sources:
  - include_dirs:
      - hw
    files:
      - hw/snd_pkg.sv
      - hw/snd_cmd_latch.sv
      - hw/snd_ram.sv
      - hw/snd_timer.sv
      - hw/snd_mixer.sv
      - hw/snd_map.sv
      - hw/snd_board.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/snd_board_tb.sv
